/* Makefile */
BIN := obj_dir/VflashLoaderTb

.PHONY: all run clean

all: run

$(BIN): sim.f $(shell cat sim.f)
	verilator --binary --assert --timing --top-module flashLoaderTb -f sim.f

run: $(BIN)
	./$(BIN) > sim.log 2>&1 || echo "Testbench failed" >> sim.log
	cat sim.log
	@if grep -q "Testbench failed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

/* sim.f */
source/ldrPkg.sv
source/spiByteEngine.sv
source/flashBootFsm.sv
source/romWordPacker.sv
source/flashLoader.sv
verif/spiFlashModel.sv
verif/flashLoader_props.sv
verif/flashLoaderTb.sv

/* source/flashBootFsm.sv */
`timescale 1ns/100ps
//////////////////////////////////////////////////////////////////////
// Boot sequencer: reset, wake-up, JEDEC ID, then one read transaction
// The packer must raise wordPending on the edge that takes the 8th byte
// clear stays high outside ReadData so command bytes are not packed
//////////////////////////////////////////////////////////////////////
module flashBootFsm (
  input  logic              clkH,
  input  logic              arstN,
  input  logic              startValid,
  input  ldrPkg::flashAddrT startAddr,
  input  logic              byteBusy,
  input  logic              rxValid,
  input  ldrPkg::byteT      rxByte,
  input  logic              wordPending,
  input  logic              lastWritten,
  output logic              startReady,
  output logic              byteSend,
  output ldrPkg::byteT      txByte,
  output logic              spiCsN,
  output logic              clear,
  output logic              busy,
  output logic              done,
  output ldrPkg::byteT      sizeCode
);
  import ldrPkg::*;

  ldrStateE   state;
  ldrStateE   stateNext;
  flashAddrT  flashAddr;
  logic [7:0] delayCnt;
  logic [1:0] byteCnt;
  logic       byteIssued;
  logic       delayZero;
  logic       lastByte;
  logic       addr4b;
  logic       dataHold;

  // States that move bytes with chip select low
  function automatic logic isCmd(ldrStateE s);
    return s inside {ResetEnable, Reset, WakeUp, IdCmd, IdByte,
                     ReadCmd, ReadAddr, ReadData};
  endfunction

  assign delayZero = delayCnt == 8'h0;
  assign lastByte  = byteCnt == 2'd0;
  assign addr4b    = sizeCode > Addr4bLimit;
  assign dataHold  = (state == ReadData) && wordPending;

  assign startReady = state == Idle;
  assign busy       = !(state inside {Idle, Done});
  assign done       = state == Done;
  assign clear      = state != ReadData;
  assign byteSend   = isCmd(state) && !byteIssued && !byteBusy && !dataHold;

  always_comb begin
    case (state)
      ResetEnable: txByte = OpResetEnable;
      Reset:       txByte = OpReset;
      WakeUp:      txByte = OpWakeUp;
      IdCmd:       txByte = OpReadId;
      ReadCmd:     txByte = addr4b ? OpRead4 : OpRead3;
      // Address goes out MSB first
      ReadAddr:    txByte = flashAddr[{byteCnt, 3'b000} +: 8];
      default:     txByte = OpDummy;
    endcase
  end

  always_comb begin
    stateNext = state;
    case (state)
      Idle:           if (startValid) stateNext = ResetEnable;
      ResetEnable:    if (rxValid) stateNext = ResetEnableGap;
      ResetEnableGap: if (delayZero) stateNext = Reset;
      Reset:          if (rxValid) stateNext = ResetGap;
      ResetGap:       if (delayZero) stateNext = WakeUp;
      WakeUp:         if (rxValid) stateNext = WakeUpGap;
      WakeUpGap:      if (delayZero) stateNext = IdCmd;
      IdCmd:          if (rxValid) stateNext = IdByte;
      IdByte:         if (rxValid && lastByte) stateNext = IdGap;
      IdGap:          if (delayZero) stateNext = ReadCmd;
      ReadCmd:        if (rxValid) stateNext = ReadAddr;
      ReadAddr:       if (rxValid && lastByte) stateNext = ReadData;
      ReadData:       if (lastWritten) stateNext = Done;
      default:        stateNext = Idle;
    endcase
  end

  always_ff @(posedge clkH or negedge arstN) begin
    if (!arstN) begin
      state      <= Idle;
      spiCsN     <= 1'b1;
      byteIssued <= 1'b0;
      byteCnt    <= 2'd0;
      delayCnt   <= 8'h0;
      sizeCode   <= 8'h0;
    end else begin
      state  <= stateNext;
      spiCsN <= !isCmd(stateNext);
      if (byteSend) begin
        byteIssued <= 1'b1;
      end else if (rxValid) begin
        byteIssued <= 1'b0;
      end
      if (!delayZero) begin
        delayCnt <= delayCnt - 8'd1;
      end
      if (rxValid) begin
        case (state)
          ResetEnable:   delayCnt <= DelayShort;
          Reset, WakeUp: delayCnt <= DelayLong;
          IdCmd:         byteCnt <= 2'd2;
          IdByte: begin
            byteCnt <= byteCnt - 2'd1;
            // Third ID byte is the density code
            if (lastByte) begin
              sizeCode <= rxByte;
              delayCnt <= DelayLong;
            end
          end
          ReadCmd:       byteCnt <= addr4b ? 2'd3 : 2'd2;
          ReadAddr:      byteCnt <= byteCnt - 2'd1;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clkH) begin
    if (startValid && startReady) begin
      flashAddr <= startAddr;
    end
  end

endmodule

/* source/flashLoader.sv */
`timescale 1ns/100ps
//////////////////////////////////////////////////////////////////////
// Flash boot loader top: one start copies RomWords words from SPI flash
// memWrValid holds address and data until memWrReady is seen
//////////////////////////////////////////////////////////////////////
module flashLoader (
  input  logic              clkH,
  input  logic              arstN,
  input  logic              startValid,
  input  ldrPkg::flashAddrT startAddr,
  output logic              startReady,
  output logic              spiSck,
  output logic              spiMosi,
  input  logic              spiMiso,
  output logic              spiCsN,
  output logic              memWrValid,
  output ldrPkg::memAddrT   memWrAddr,
  output ldrPkg::memWordT   memWrData,
  input  logic              memWrReady,
  output logic              busy,
  output logic              done,
  output ldrPkg::byteT      sizeCode
);
  import ldrPkg::*;

  logic byteSend;
  logic byteBusy;
  logic rxValid;
  logic clear;
  logic wordPending;
  logic lastWritten;
  byteT txByte;
  byteT rxByte;

  flashBootFsm bootFsm_i (
    .clkH(clkH), .arstN(arstN),
    .startValid(startValid), .startAddr(startAddr), .startReady(startReady),
    .byteBusy(byteBusy), .rxValid(rxValid), .rxByte(rxByte),
    .wordPending(wordPending), .lastWritten(lastWritten),
    .byteSend(byteSend), .txByte(txByte), .spiCsN(spiCsN), .clear(clear),
    .busy(busy), .done(done), .sizeCode(sizeCode)
  );

  spiByteEngine spiEngine_i (
    .clkH(clkH), .arstN(arstN),
    .byteSend(byteSend), .txByte(txByte), .spiMiso(spiMiso),
    .byteBusy(byteBusy), .rxValid(rxValid), .rxByte(rxByte),
    .spiSck(spiSck), .spiMosi(spiMosi)
  );

  romWordPacker packer_i (
    .clkH(clkH), .arstN(arstN), .clear(clear),
    .rxValid(rxValid), .rxByte(rxByte), .memWrReady(memWrReady),
    .wordPending(wordPending), .lastWritten(lastWritten),
    .memWrValid(memWrValid), .memWrAddr(memWrAddr), .memWrData(memWrData)
  );

endmodule

/* source/ldrPkg.sv */
//////////////////////////////////////////////////////////////////////
// Types, flash opcodes and timing constants for the flash boot loader
// Delays and BaudDiv count clkH cycles; BaudDiv must be at least 1
// RomWords is expected to be a power of two
//////////////////////////////////////////////////////////////////////
package ldrPkg;

  typedef logic [7:0]  byteT;
  typedef logic [63:0] memWordT;
  // Byte address bits 31 to 3
  typedef logic [28:0] memAddrT;
  typedef logic [31:0] flashAddrT;

  typedef enum logic [7:0] {
    OpResetEnable = 8'h66,
    OpReset       = 8'h99,
    OpWakeUp      = 8'hAB,
    OpReadId      = 8'h9F,
    OpRead3       = 8'h03,
    OpRead4       = 8'h13,
    OpDummy       = 8'hFF
  } flashOpE;

  typedef enum logic [3:0] {
    Idle,
    ResetEnable,
    ResetEnableGap,
    Reset,
    ResetGap,
    WakeUp,
    WakeUpGap,
    IdCmd,
    IdByte,
    IdGap,
    ReadCmd,
    ReadAddr,
    ReadData,
    Done
  } ldrStateE;

  localparam int         BaudDiv     = 3;
  localparam int         BaudCntW    = $clog2(BaudDiv + 1);
  localparam logic [7:0] DelayShort  = 8'd63;
  localparam logic [7:0] DelayLong   = 8'd255;
  localparam byteT       Addr4bLimit = 8'h18;
  localparam memAddrT    RomBase     = 29'h0;
  localparam int         RomWords    = 16;
  localparam int         WordCntW    = $clog2(RomWords);

endpackage

/* source/romWordPacker.sv */
`timescale 1ns/100ps
//////////////////////////////////////////////////////////////////////
// Packs SPI bytes into little-endian 64-bit ROM words
// Expects no new byte while wordPending is high
//////////////////////////////////////////////////////////////////////
module romWordPacker (
  input  logic            clkH,
  input  logic            arstN,
  input  logic            clear,
  input  logic            rxValid,
  input  ldrPkg::byteT    rxByte,
  input  logic            memWrReady,
  output logic            wordPending,
  output logic            lastWritten,
  output logic            memWrValid,
  output ldrPkg::memAddrT memWrAddr,
  output ldrPkg::memWordT memWrData
);
  import ldrPkg::*;

  logic [2:0]          byteCnt;
  logic [WordCntW-1:0] wordCnt;
  logic                wordXfer;

  assign wordXfer    = memWrValid && memWrReady;
  assign wordPending = memWrValid;
  assign lastWritten = wordXfer && (wordCnt == WordCntW'(RomWords - 1));

  always_ff @(posedge clkH or negedge arstN) begin
    if (!arstN) begin
      memWrValid <= 1'b0;
      byteCnt    <= 3'd0;
      wordCnt    <= '0;
      memWrAddr  <= RomBase;
    end else if (clear) begin
      memWrValid <= 1'b0;
      byteCnt    <= 3'd0;
      wordCnt    <= '0;
      memWrAddr  <= RomBase;
    end else begin
      if (rxValid) begin
        byteCnt <= byteCnt + 3'd1;
        if (byteCnt == 3'd7) begin
          memWrValid <= 1'b1;
        end
      end
      if (wordXfer) begin
        memWrValid <= 1'b0;
        wordCnt    <= wordCnt + WordCntW'(1);
        memWrAddr  <= memWrAddr + 29'd1;
      end
    end
  end

  // First byte drifts down to bits 7:0
  always_ff @(posedge clkH) begin
    if (rxValid && !clear) begin
      memWrData <= {rxByte, memWrData[63:8]};
    end
  end

endmodule

/* source/spiByteEngine.sv */
`timescale 1ns/100ps
//////////////////////////////////////////////////////////////////////
// SPI mode 0 byte master, MSB first, SCK idles low
// One byte takes 16 x BaudDiv cycles; byteSend is honoured only while
// byteBusy is low. Chip select is left to the caller
//////////////////////////////////////////////////////////////////////
module spiByteEngine (
  input  logic         clkH,
  input  logic         arstN,
  input  logic         byteSend,
  input  ldrPkg::byteT txByte,
  input  logic         spiMiso,
  output logic         byteBusy,
  output logic         rxValid,
  output ldrPkg::byteT rxByte,
  output logic         spiSck,
  output logic         spiMosi
);
  import ldrPkg::*;

  logic [BaudCntW-1:0] baudCnt;
  logic [3:0]          halfCnt;
  logic                baudTick;
  byteT                txShift;

  // End of one SCK half period
  assign baudTick = byteBusy && (baudCnt == BaudCntW'(BaudDiv - 1));
  assign spiMosi  = txShift[7];

  always_ff @(posedge clkH or negedge arstN) begin
    if (!arstN) begin
      byteBusy <= 1'b0;
      rxValid  <= 1'b0;
      spiSck   <= 1'b0;
      baudCnt  <= '0;
      halfCnt  <= 4'd0;
    end else begin
      rxValid <= 1'b0;
      if (byteSend && !byteBusy) begin
        byteBusy <= 1'b1;
        baudCnt  <= '0;
        halfCnt  <= 4'd0;
      end else if (baudTick) begin
        baudCnt <= '0;
        spiSck  <= !spiSck;
        halfCnt <= halfCnt + 4'd1;
        // Sixteenth edge brings SCK back low
        if (halfCnt == 4'd15) begin
          byteBusy <= 1'b0;
          rxValid  <= 1'b1;
        end
      end else if (byteBusy) begin
        baudCnt <= baudCnt + BaudCntW'(1);
      end
    end
  end

  // Next bit goes out after each falling edge
  always_ff @(posedge clkH or negedge arstN) begin
    if (!arstN) begin
      txShift <= 8'h0;
    end else if (byteSend && !byteBusy) begin
      txShift <= txByte;
    end else if (baudTick && spiSck) begin
      txShift <= {txShift[6:0], 1'b0};
    end
  end

  // Sample on the rising edge
  always_ff @(posedge clkH) begin
    if (baudTick && !spiSck) begin
      rxByte <= {rxByte[6:0], spiMiso};
    end
  end

endmodule

/* verif/flashLoaderTb.sv */
`timescale 1ns/100ps
//////////////////////////////////////////////////////////////////////
// Two boot runs with 3-byte then 4-byte addressing under random memWrReady
// Expected words come from the flash data rule a*7+0x5A
//////////////////////////////////////////////////////////////////////
module flashLoaderTb;
  import ldrPkg::*;

  localparam int RunTimeout = 40000;

  logic      clkH = 1'b0;
  logic      arstN;
  logic      startValid;
  flashAddrT startAddr;
  logic      startReady;
  logic      spiSck;
  logic      spiMosi;
  logic      spiMiso;
  logic      spiCsN;
  logic      memWrValid;
  memAddrT   memWrAddr;
  memWordT   memWrData;
  logic      memWrReady;
  logic      busy;
  logic      done;
  byteT      sizeCode;
  byteT      idSize;
  // Flash address the read really starts from
  flashAddrT readBase;
  int        xferCnt;
  int        acceptCnt;
  int        doneCnt;

  flashLoader flashLoader_i (
    .clkH(clkH), .arstN(arstN),
    .startValid(startValid), .startAddr(startAddr), .startReady(startReady),
    .spiSck(spiSck), .spiMosi(spiMosi), .spiMiso(spiMiso), .spiCsN(spiCsN),
    .memWrValid(memWrValid), .memWrAddr(memWrAddr), .memWrData(memWrData),
    .memWrReady(memWrReady), .busy(busy), .done(done), .sizeCode(sizeCode)
  );

  spiFlashModel flashModel_i (
    .spiSck(spiSck), .spiMosi(spiMosi), .spiCsN(spiCsN),
    .idSize(idSize), .spiMiso(spiMiso)
  );

  bind flashLoader flashLoader_props props_i (
    .clkH(clkH), .arstN(arstN), .spiSck(spiSck), .spiCsN(spiCsN), .busy(busy),
    .memWrValid(memWrValid), .memWrReady(memWrReady),
    .memWrAddr(memWrAddr), .memWrData(memWrData)
  );

  always #50 clkH = !clkH;

  // Eight flash bytes from base + 8i with the first in bits 7:0
  function automatic memWordT expWord(flashAddrT base, int i);
    memWordT   w;
    flashAddrT a;
    w = '0;
    for (int k = 0; k < 8; k++) begin
      a = base + flashAddrT'(8 * i + k);
      w = w | (memWordT'(byteT'(a * 7 + 32'h5A)) << (8 * k));
    end
    return w;
  endfunction

  function automatic byteT expOpcode(int k, logic wide);
    case (k)
      0: return OpResetEnable;
      1: return OpReset;
      2: return OpWakeUp;
      3: return OpReadId;
      default: return wide ? OpRead4 : OpRead3;
    endcase
  endfunction

  task automatic stopWithError(string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic checkWord(string name, memWordT got, memWordT exp);
    if (got !== exp) begin
      stopWithError($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic checkAddr(string name, memAddrT got, memAddrT exp);
    if (got !== exp) begin
      stopWithError($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic checkByte(string name, byteT got, byteT exp);
    if (got !== exp) begin
      stopWithError($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic checkBit(string name, logic got, logic exp);
    if (got !== exp) begin
      stopWithError($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic waitStart();
    int cycles;
    cycles = 0;
    do begin
      @(posedge clkH);
      cycles++;
      if (cycles > 100) begin
        stopWithError("start request was not accepted within 100 cycles");
      end
    end while (!(startValid && startReady));
  endtask

  task automatic waitDone();
    int cycles;
    cycles = 0;
    do begin
      @(posedge clkH);
      cycles++;
      if (cycles > RunTimeout) begin
        stopWithError("loader did not signal done before the timeout");
      end
    end while (!done);
  endtask

  task automatic bootRun(byteT code, flashAddrT addr, int runNo);
    int   opBase;
    int   len;
    logic wide;
    opBase = flashModel_i.opLog.size();
    wide   = code > Addr4bLimit;
    len    = wide ? 4 : 3;
    idSize     <= code;
    readBase   <= wide ? addr : {8'h00, addr[23:0]};
    startAddr  <= addr;
    startValid <= 1'b1;
    waitStart();
    // startValid stays high through the run
    waitDone();
    startValid <= 1'b0;
    // The cycle after done is counted too, so a long done shows up
    repeat (2) @(posedge clkH);
    checkByte("done pulses", byteT'(doneCnt), 8'd1);
    checkByte("transfers", byteT'(xferCnt), byteT'(RomWords));
    checkByte("starts accepted", byteT'(acceptCnt), byteT'(runNo));
    checkByte("sizeCode", sizeCode, code);
    checkByte("opcodes logged", byteT'(flashModel_i.opLog.size() - opBase), 8'd5);
    for (int k = 0; k < 5; k++) begin
      checkByte($sformatf("opcode %0d", k), flashModel_i.opLog[opBase + k],
                expOpcode(k, wide));
    end
    checkByte("address bytes", byteT'(flashModel_i.addrLog.size()), byteT'(len));
    for (int k = 0; k < len; k++) begin
      checkByte($sformatf("address byte %0d", k), flashModel_i.addrLog[k],
                byteT'(addr >> (8 * (len - 1 - k))));
    end
  endtask

  // Memory back-pressure about a third of the time
  initial begin
    void'($urandom(32'h6235_3c76));
    memWrReady = 1'b0;
    forever begin
      @(posedge clkH);
      memWrReady <= ($urandom % 3) != 0;
    end
  end

  always @(posedge clkH) begin
    if (arstN) begin
      if (startValid && startReady) begin
        acceptCnt <= acceptCnt + 1;
        xferCnt   <= 0;
        doneCnt   <= 0;
      end
      if (busy) begin
        checkBit("startReady while busy", startReady, 1'b0);
      end
      if (memWrValid && memWrReady) begin
        checkBit("transfer within RomWords", xferCnt < RomWords, 1'b1);
        checkAddr("memWrAddr", memWrAddr, RomBase + memAddrT'(xferCnt));
        checkWord("memWrData", memWrData, expWord(readBase, xferCnt));
        xferCnt <= xferCnt + 1;
      end
      if (done) begin
        checkBit("all transfers before done", xferCnt == RomWords, 1'b1);
        doneCnt <= doneCnt + 1;
      end
    end
  end

  initial begin
    arstN      = 1'b0;
    startValid = 1'b0;
    startAddr  = '0;
    idSize     = 8'h00;
    readBase   = '0;
    repeat (4) @(posedge clkH);
    arstN <= 1'b1;
    @(posedge clkH);
    checkBit("startReady", startReady, 1'b1);
    checkBit("busy", busy, 1'b0);
    checkBit("done", done, 1'b0);
    checkBit("memWrValid", memWrValid, 1'b0);
    checkBit("spiCsN", spiCsN, 1'b1);
    // Size code at the limit keeps 3-byte addressing
    bootRun(8'h18, 32'hC3_01_23_40, 1);
    bootRun(8'h19, 32'h2A_51_08_05, 2);
    $display("Testbench passed");
    $finish;
  end

endmodule

/* verif/flashLoader_props.sv */
`timescale 1ns/100ps
//////////////////////////////////////////////////////////////////////
// SPI framing and memory write handshake rules for flashLoader
// Sampled on clkH, inactive while arstN is low
//////////////////////////////////////////////////////////////////////
module flashLoader_props (
  input logic            clkH,
  input logic            arstN,
  input logic            spiSck,
  input logic            spiCsN,
  input logic            busy,
  input logic            memWrValid,
  input logic            memWrReady,
  input ldrPkg::memAddrT memWrAddr,
  input ldrPkg::memWordT memWrData
);

  sckIdleCheck: assert property (@(posedge clkH) disable iff (!arstN)
    spiCsN |-> !spiSck)
    else $error("spiSck is high while spiCsN is high");

  // Held word must not change under back-pressure
  memHoldCheck: assert property (@(posedge clkH) disable iff (!arstN)
    memWrValid && !memWrReady |=>
      memWrValid && $stable(memWrAddr) && $stable(memWrData))
    else $error("memory write dropped or changed before memWrReady");

  csIdleCheck: assert property (@(posedge clkH) disable iff (!arstN)
    !busy |-> spiCsN)
    else $error("spiCsN is low while the loader is not busy");

endmodule

/* verif/spiFlashModel.sv */
`timescale 1ns/100ps
//////////////////////////////////////////////////////////////////////
// Behavioral SPI flash, mode 0, shifts out on the falling SCK edge
// 0x9F answers 0xEF, 0x40, idSize; data byte at a is low byte of a*7+0x5A
// Logs the first byte of every chip-select window and the read address
//////////////////////////////////////////////////////////////////////
module spiFlashModel (
  input  logic         spiSck,
  input  logic         spiMosi,
  input  logic         spiCsN,
  input  ldrPkg::byteT idSize,
  output logic         spiMiso
);
  import ldrPkg::*;

  byteT      opLog[$];
  byteT      addrLog[$];
  byteT      opcode;
  byteT      inShift;
  byteT      outShift;
  flashAddrT readAddr;
  logic      prevSck;
  int        bitCnt;
  int        byteIdx;

  function automatic logic isRead();
    return opcode == OpRead3 || opcode == OpRead4;
  endfunction

  function automatic int addrBytes();
    return (opcode == OpRead4) ? 4 : 3;
  endfunction

  // Byte returned during transfer idx of the window
  function automatic byteT nextOut(int idx);
    flashAddrT a;
    if (opcode == OpReadId) begin
      case (idx)
        1: return 8'hEF;
        2: return 8'h40;
        3: return idSize;
        default: return 8'h00;
      endcase
    end
    if (isRead() && idx > addrBytes()) begin
      a = readAddr + flashAddrT'(idx - addrBytes() - 1);
      return byteT'(a * 7 + 32'h5A);
    end
    return 8'h00;
  endfunction

  initial begin
    spiMiso = 1'b0;
    prevSck = 1'b0;
    forever begin
      @(spiSck or spiCsN);
      if (spiCsN !== 1'b0) begin
        outShift = 8'h00;
      end else if (spiSck === prevSck) begin
        // Chip select just fell
        bitCnt   = 0;
        byteIdx  = 0;
        opcode   = 8'h00;
        outShift = 8'h00;
        spiMiso  = 1'b0;
      end else if (spiSck) begin
        inShift = {inShift[6:0], spiMosi};
        bitCnt++;
        if (bitCnt == 8) begin
          if (byteIdx == 0) begin
            opcode = inShift;
            opLog.push_back(inShift);
            readAddr = '0;
            if (isRead()) begin
              addrLog.delete();
            end
          end else if (isRead() && byteIdx <= addrBytes()) begin
            addrLog.push_back(inShift);
            readAddr = {readAddr[23:0], inShift};
          end
          byteIdx++;
          bitCnt = 0;
        end
      end else begin
        if (bitCnt == 0) begin
          outShift = nextOut(byteIdx);
        end else begin
          outShift = {outShift[6:0], 1'b0};
        end
        spiMiso = outShift[7];
      end
      prevSck = spiSck;
    end
  end

endmodule
